//--- hdl/shade_params.svh
`ifndef SHADE_PARAMS_SVH
`define SHADE_PARAMS_SVH

// Ray index width, 32 rays in flight.
`define RAY_ID_W 5

// Unsigned Q1.15 channel format.
`define CHAN_W 16
`define FRAC_W 15

// 1.0 in Q1.15.
`define ONE_Q 16'h8000

// Finished-ray FIFO depth, a power of two.
`define DONE_DEPTH 8

`endif

//--- hdl/color_pkg.sv
`default_nettype none

`include "shade_params.svh"

package color_pkg;

  // One unsigned Q1.15 channel.
  typedef logic [`CHAN_W-1:0] chan_t;

  typedef struct packed {
    chan_t red;
    chan_t green;
    chan_t blue;
  } color_t;

  // Store word, accumulated radiance and path throughput.
  typedef struct packed {
    color_t b;
    color_t m;
  } bm_entry_t;

endpackage

`default_nettype wire

//--- hdl/ray_pkg.sv
`default_nettype none

`include "shade_params.svh"

package ray_pkg;

  import color_pkg::*;

  typedef logic [`RAY_ID_W-1:0] ray_id_t;

  typedef enum logic [1:0] {
    OP_INIT   = 2'd0, // Reset entry, no output.
    OP_BOUNCE = 2'd1,
    OP_LAST   = 2'd2  // Final bounce, emits colour.
  } hit_op_t;

  // Input hit record.
  typedef struct packed {
    hit_op_t op;
    ray_id_t ray_id;
    color_t  direct;
    color_t  spec;
  } hit_t;

  // Finished ray.
  typedef struct packed {
    ray_id_t ray_id;
    color_t  color;
  } ray_done_t;

endpackage

`default_nettype wire

//--- hdl/skid_buf.sv
`default_nettype none
`timescale 1ns/1ps

module skid_buf
  import ray_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  input  logic s_valid,
  input  hit_t s_data,
  output logic s_stall,
  output logic m_valid,
  output hit_t m_data,
  input  logic m_stall
);

  hit_t main_data;
  hit_t spare_data;
  logic main_valid;
  logic spare_valid;
  logic take_in;
  logic take_out;
  logic main_free;

  assign take_in   = s_valid & ~s_stall;
  assign take_out  = main_valid & ~m_stall;
  assign main_free = ~main_valid | take_out;

  // Stall only when the spare slot is occupied.
  assign s_stall = spare_valid;
  assign m_valid = main_valid;
  assign m_data  = main_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      main_valid  <= 1'b0;
      spare_valid <= 1'b0;
    end else if (main_free) begin
      main_valid  <= spare_valid | take_in;
      spare_valid <= 1'b0;
    end else if (take_in) begin
      spare_valid <= 1'b1; // Downstream stalled, park the record.
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      main_data <= spare_valid ? spare_data : s_data;
    end
    if (take_in && !main_free) begin
      spare_data <= s_data;
    end
  end

endmodule

`default_nettype wire

//--- hdl/bm_store.sv
`default_nettype none
`timescale 1ns/1ps

`include "shade_params.svh"

module bm_store
  import color_pkg::*;
  import ray_pkg::*;
(
  input  logic      clk,
  input  logic      we,
  input  ray_id_t   waddr,
  input  bm_entry_t wdata,
  input  ray_id_t   raddr,
  output bm_entry_t rdata
);

  localparam int DEPTH = 2 ** `RAY_ID_W;

  bm_entry_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read returns the old word on a same-address write.
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

//--- hdl/bounce_accum.sv
`default_nettype none
`timescale 1ns/1ps

`include "shade_params.svh"

module bounce_accum
  import color_pkg::*;
  import ray_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 hit_valid,
  input  hit_t                 hit,
  output logic                 hit_stall,
  input  logic [`RAY_ID_W-1:0] free_slots,
  output logic                 push,
  output ray_done_t            push_data
);

  logic      advance;
  logic      s1_valid;
  logic      s2_valid;
  hit_t      s1_hit;
  hit_t      s2_hit;
  ray_id_t   raddr;
  bm_entry_t rdata;
  bm_entry_t old_entry;
  bm_entry_t wdata;
  logic      we;
  logic      fwd_hit;
  bm_entry_t fwd_data;
  color_t    new_b;
  color_t    new_m;

  // Saturating Q1.15 product.
  function automatic chan_t q_mul(chan_t a, chan_t b);
    logic [2*`CHAN_W-1:0] full;
    logic [2*`CHAN_W-1:0] shifted;
    full    = a * b;
    shifted = full >> `FRAC_W;
    if (|shifted[2*`CHAN_W-1:`CHAN_W]) begin
      return '1;
    end
    return shifted[`CHAN_W-1:0];
  endfunction

  function automatic chan_t q_add(chan_t a, chan_t b);
    logic [`CHAN_W:0] sum;
    sum = a + b;
    return sum[`CHAN_W] ? '1 : sum[`CHAN_W-1:0];
  endfunction

  function automatic color_t c_mul(color_t a, color_t b);
    color_t r;
    r.red   = q_mul(a.red, b.red);
    r.green = q_mul(a.green, b.green);
    r.blue  = q_mul(a.blue, b.blue);
    return r;
  endfunction

  function automatic color_t c_add(color_t a, color_t b);
    color_t r;
    r.red   = q_add(a.red, b.red);
    r.green = q_add(a.green, b.green);
    r.blue  = q_add(a.blue, b.blue);
    return r;
  endfunction

  // Keep two slots spare for records already in the pipe.
  assign hit_stall = (free_slots < 3);
  assign advance   = ~hit_stall;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      fwd_hit  <= 1'b0;
    end else if (advance) begin
      s1_valid <= hit_valid;
      s2_valid <= s1_valid;
      fwd_hit  <= s1_valid & s2_valid & (s1_hit.ray_id == s2_hit.ray_id);
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      s1_hit   <= hit;
      s2_hit   <= s1_hit;
      fwd_data <= wdata;
    end
  end

  // While frozen, keep re-reading the entry of the record held in stage 2.
  assign raddr = advance ? s1_hit.ray_id : s2_hit.ray_id;

  bm_store u_store (
    .clk   (clk),
    .we    (we),
    .waddr (s2_hit.ray_id),
    .wdata (wdata),
    .raddr (raddr),
    .rdata (rdata)
  );

  assign old_entry = fwd_hit ? fwd_data : rdata;

  assign new_b = c_add(old_entry.b, c_mul(old_entry.m, s2_hit.direct));
  assign new_m = c_mul(old_entry.m, s2_hit.spec);

  always_comb begin
    case (s2_hit.op)
      OP_BOUNCE: begin
        wdata.b = new_b;
        wdata.m = new_m;
      end
      default: begin // Init and last both restart the path.
        wdata.b = '0;
        wdata.m = '{red: `ONE_Q, green: `ONE_Q, blue: `ONE_Q};
      end
    endcase
  end

  assign we   = advance & s2_valid;
  assign push = advance & s2_valid & (s2_hit.op == OP_LAST);

  assign push_data.ray_id = s2_hit.ray_id;
  assign push_data.color  = new_b;

endmodule

`default_nettype wire

//--- hdl/done_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "shade_params.svh"

module done_fifo
  import ray_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 push,
  input  ray_done_t            push_data,
  output logic                 pop_valid,
  output ray_done_t            pop_data,
  input  logic                 pop_stall,
  output logic [`RAY_ID_W-1:0] free_slots
);

  localparam int PTR_W = $clog2(`DONE_DEPTH);
  localparam int FS_W  = `RAY_ID_W;

  ray_done_t        mem [`DONE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             pop;

  assign pop_valid  = (count != '0);
  assign pop        = pop_valid & ~pop_stall;
  assign pop_data   = mem[rd_ptr];
  assign free_slots = FS_W'(`DONE_DEPTH - count);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1; // Wraps, depth is a power of two.
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/shade_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "shade_params.svh"

module shade_top
  import ray_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      in_valid,
  input  hit_t      in_data,
  output logic      in_stall,
  output logic      out_valid,
  output ray_done_t out_data,
  input  logic      out_stall
);

  logic                 hit_valid;
  hit_t                 hit;
  logic                 hit_stall;
  logic                 push;
  ray_done_t            push_data;
  logic [`RAY_ID_W-1:0] free_slots;

  skid_buf u_skid (
    .clk     (clk),
    .arst_n  (arst_n),
    .s_valid (in_valid),
    .s_data  (in_data),
    .s_stall (in_stall),
    .m_valid (hit_valid),
    .m_data  (hit),
    .m_stall (hit_stall)
  );

  bounce_accum u_accum (
    .clk        (clk),
    .arst_n     (arst_n),
    .hit_valid  (hit_valid),
    .hit        (hit),
    .hit_stall  (hit_stall),
    .free_slots (free_slots),
    .push       (push),
    .push_data  (push_data)
  );

  done_fifo u_fifo (
    .clk        (clk),
    .arst_n     (arst_n),
    .push       (push),
    .push_data  (push_data),
    .pop_valid  (out_valid),
    .pop_data   (out_data),
    .pop_stall  (out_stall),
    .free_slots (free_slots)
  );

endmodule

`default_nettype wire

//--- tests/clk_gen.sv
`default_nettype none
`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period.
  end

  initial begin
    arst_n = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1; // Release away from the active edge.
  end

endmodule

`default_nettype wire

//--- tests/shade_checker.sv
`default_nettype none
`timescale 1ns/1ps

`include "shade_params.svh"

module shade_checker
  import ray_pkg::*;
(
  input logic                 clk,
  input logic                 arst_n,
  input logic                 in_valid,
  input hit_t                 in_data,
  input logic                 in_stall,
  input logic                 out_valid,
  input ray_done_t            out_data,
  input logic                 out_stall,
  input logic [`RAY_ID_W-1:0] free_slots
);

  // Sender must hold a stalled record.
  in_hold: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid && in_stall |=> in_valid && $stable(in_data))
    else $error("in_data changed while in_stall was high");

  out_hold: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && out_stall |=> out_valid && $stable(out_data))
    else $error("out_data changed while out_stall was high");

  out_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else $error("out_valid high during reset");

  slots_range: assert property (@(posedge clk) disable iff (!arst_n)
    free_slots <= `DONE_DEPTH)
    else $error("free slot count above FIFO depth");

endmodule

bind shade_top shade_checker u_checker (
  .clk        (clk),
  .arst_n     (arst_n),
  .in_valid   (in_valid),
  .in_data    (in_data),
  .in_stall   (in_stall),
  .out_valid  (out_valid),
  .out_data   (out_data),
  .out_stall  (out_stall),
  .free_slots (free_slots)
);

`default_nettype wire

//--- tests/shade_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "shade_params.svh"

module shade_tb
  import color_pkg::*;
  import ray_pkg::*;
();

  localparam longint MAX_Q = (64'd1 << `CHAN_W) - 1;

  logic      clk;
  logic      arst_n;
  logic      in_valid;
  hit_t      in_data;
  logic      in_stall;
  logic      out_valid;
  ray_done_t out_data;
  logic      out_stall;

  int        seed = 32'h1434;
  hit_t      stim_q[$];
  ray_done_t exp_q[$];
  color_t    b_model [2**`RAY_ID_W];
  color_t    m_model [2**`RAY_ID_W];
  int        last_count;
  int        out_count;
  int        gap_from;
  int        stall_pct;
  bit        gaps_on;
  bit        burst_on;
  bit        started;

  clk_gen u_clk (.clk(clk), .arst_n(arst_n));

  shade_top u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_stall  (in_stall),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_stall (out_stall)
  );

  function automatic int rand_below(int n);
    return int'({$random(seed)} % n);
  endfunction

  function automatic color_t rand_color();
    color_t c;
    c.red   = chan_t'($random(seed));
    c.green = chan_t'($random(seed));
    c.blue  = chan_t'($random(seed));
    return c;
  endfunction

  // Full product over 2^FRAC_W clipped at the channel maximum.
  function automatic chan_t scale_chan(chan_t x, chan_t k);
    longint p;
    p = (longint'(x) * longint'(k)) >>> `FRAC_W;
    return (p > MAX_Q) ? chan_t'(MAX_Q) : chan_t'(p);
  endfunction

  function automatic chan_t add_chan(chan_t a, chan_t c);
    longint s;
    s = longint'(a) + longint'(c);
    return (s > MAX_Q) ? chan_t'(MAX_Q) : chan_t'(s);
  endfunction

  function automatic color_t color_scale(color_t a, color_t k);
    return '{red: scale_chan(a.red, k.red), green: scale_chan(a.green, k.green),
             blue: scale_chan(a.blue, k.blue)};
  endfunction

  function automatic color_t color_sum(color_t a, color_t c);
    return '{red: add_chan(a.red, c.red), green: add_chan(a.green, c.green),
             blue: add_chan(a.blue, c.blue)};
  endfunction

  // Reference update in acceptance order.
  task automatic model_accept(input hit_t h);
    color_t    nb;
    ray_done_t d;
    nb = color_sum(b_model[h.ray_id], color_scale(m_model[h.ray_id], h.direct));
    case (h.op)
      OP_BOUNCE: begin
        b_model[h.ray_id] = nb;
        m_model[h.ray_id] = color_scale(m_model[h.ray_id], h.spec);
      end
      default: begin
        if (h.op == OP_LAST) begin
          d.ray_id = h.ray_id;
          d.color  = nb;
          exp_q.push_back(d);
        end
        b_model[h.ray_id] = '0;
        m_model[h.ray_id] = '{red: `ONE_Q, green: `ONE_Q, blue: `ONE_Q};
      end
    endcase
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_color(input color_t got, input color_t want, input string what);
    if (got !== want)
      report_mismatch($sformatf("%s colour %h/%h/%h, expected %h/%h/%h", what,
                                got.red, got.green, got.blue,
                                want.red, want.green, want.blue));
  endtask

  task automatic check_done(input ray_done_t got, input ray_done_t want);
    if (got.ray_id !== want.ray_id)
      report_mismatch($sformatf("ray id %0d, expected %0d", got.ray_id, want.ray_id));
    else
      check_color(got.color, want.color, $sformatf("ray %0d", want.ray_id));
  endtask

  task automatic queue_hit(input hit_op_t op, input int id, input bit dark);
    hit_t h;
    h.op     = op;
    h.ray_id = ray_id_t'(id);
    h.spec   = rand_color();
    if (dark)
      h.direct = '0;
    else
      h.direct = rand_color();
    stim_q.push_back(h);
    if (op == OP_LAST)
      last_count++;
  endtask

  task automatic build_stimulus();
    for (int r = 0; r < 2**`RAY_ID_W; r++)
      queue_hit(OP_INIT, r, 1'b0);
    for (int r = 0; r < 3; r++)
      queue_hit(OP_LAST, r, 1'b1); // Dark paths give black.
    repeat (120)
      queue_hit(rand_below(5) == 0 ? OP_LAST : OP_BOUNCE, rand_below(8), 1'b0);
    // Same ray back to back exercises forwarding.
    for (int r = 16; r < 20; r++) begin
      repeat (5)
        queue_hit(OP_BOUNCE, r, 1'b0);
      queue_hit(OP_LAST, r, 1'b0);
    end
    repeat (2)
      queue_hit(OP_BOUNCE, 24, 1'b0);
    queue_hit(OP_LAST, 24, 1'b0);
    repeat (2)
      queue_hit(OP_BOUNCE, 24, 1'b0); // Reused without a new init.
    queue_hit(OP_LAST, 24, 1'b0);
    gap_from = stim_q.size();
    repeat (150)
      queue_hit(rand_below(3) == 0 ? OP_LAST : OP_BOUNCE, rand_below(32), 1'b0);
  endtask

  task automatic send_record(input hit_t h);
    bit taken;
    if (gaps_on && rand_below(4) == 0) begin
      in_valid = 1'b0;
      @(posedge clk);
      #1;
    end
    in_valid = 1'b1;
    in_data  = h;
    taken    = 1'b0;
    while (!taken) begin
      @(negedge clk);
      if (!in_stall) begin
        model_accept(h);
        taken = 1'b1;
      end
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    int cyc;
    cyc = 0;
    out_stall = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      cyc++;
      if (burst_on && (cyc % 200) < 40)
        out_stall = 1'b1; // Long stall fills the FIFO.
      else
        out_stall = (rand_below(100) < stall_pct);
    end
  end

  initial begin
    forever begin
      @(negedge clk);
      if (arst_n && out_valid && !out_stall) begin
        if (exp_q.size() == 0)
          abort_run($sformatf("Unexpected output for ray %0d with nothing pending",
                              out_data.ray_id));
        else begin
          check_done(out_data, exp_q.pop_front());
          out_count++;
        end
      end
    end
  end

  initial begin
    wait (started);
    repeat (20 * stim_q.size() + 200) @(posedge clk);
    abort_run($sformatf("Timeout: the run hung with %0d of %0d outputs received",
                        out_count, last_count));
  end

  initial begin
    in_valid  = 1'b0;
    in_data   = '0;
    stall_pct = 15;
    build_stimulus();
    wait (arst_n);
    @(posedge clk);
    #1;
    started = 1'b1;
    foreach (stim_q[i]) begin
      if (i == gap_from) begin
        gaps_on   = 1'b1;
        burst_on  = 1'b1;
        stall_pct = 40;
      end
      send_record(stim_q[i]);
    end
    in_valid = 1'b0;
    while (out_count < last_count)
      @(posedge clk);
    repeat (40) @(posedge clk); // Room for a duplicate to appear.
    if (out_count == last_count && exp_q.size() == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      abort_run($sformatf("Got %0d outputs for %0d last-bounce records",
                          out_count, last_count));
    end
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/color_pkg.sv
hdl/ray_pkg.sv
hdl/skid_buf.sv
hdl/bm_store.sv
hdl/bounce_accum.sv
hdl/done_fifo.sv
hdl/shade_top.sv
tests/clk_gen.sv
tests/shade_checker.sv
tests/shade_tb.sv

//--- Makefile
.PHONY: run clean

run: obj_dir/Vshade_tb
	@out="$$(./obj_dir/Vshade_tb)"; echo "$$out"; \
	echo "$$out" | grep -q '^sim passed$$'

obj_dir/Vshade_tb: sources.f $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
	  --top-module shade_tb -o Vshade_tb

clean:
	rm -rf obj_dir
